//--- group_pkg.sv
// ----------------------------
// Memory group shared widths and word types
// ----------------------------

package group_pkg;

  // ----------------------------
  // Data path
  // ----------------------------

  localparam int unsigned DataWidth = 32;

  // One enable per byte lane
  localparam int unsigned BeWidth = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   strb_t;

  // ----------------------------
  // Addressing
  // ----------------------------

  // Word address; bits above the memory size are dropped by the decode
  localparam int unsigned AddrWidth = 16;

  typedef logic [AddrWidth-1:0] addr_t;

  // DMA transfer length, counted in words
  localparam int unsigned LenWidth = 16;

  typedef logic [LenWidth-1:0] len_t;

endpackage

//--- tcdm_bank.sv
// ----------------------------
// Single-port TCDM bank
// Byte-masked write, read data one cycle after the request
// ----------------------------

`timescale 1ns/100ps

module tcdm_bank #(
  parameter int unsigned BankDepth = 64
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         wen_i,
  input  logic [$clog2(BankDepth)-1:0] row_i,
  input  group_pkg::data_t             wdata_i,
  input  group_pkg::strb_t             be_i,
  output group_pkg::data_t             rdata_o
);

  import group_pkg::*;

  data_t mem_q [BankDepth];
  data_t rdata_q;

  // Write only the enabled byte lanes
  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      for (int unsigned i = 0; i < BeWidth; i++) begin
        if (be_i[i]) begin
          mem_q[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Old contents are returned, also on a write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= mem_q[row_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- bank_arbiter.sv
// ----------------------------
// Round-robin arbiter for one bank
// ----------------------------

`timescale 1ns/100ps

module bank_arbiter #(
  parameter int unsigned NumInit = 5
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [NumInit-1:0]         req_i,
  output logic [NumInit-1:0]         gnt_o,
  output logic [$clog2(NumInit)-1:0] gnt_idx_o,
  output logic                       gnt_valid_o
);

  localparam int unsigned IdxWidth = $clog2(NumInit);

  logic [IdxWidth-1:0] ptr_q;

  // Search starts at the priority pointer and wraps around
  always_comb begin
    int unsigned cand;
    gnt_o       = '0;
    gnt_idx_o   = '0;
    gnt_valid_o = 1'b0;
    for (int unsigned k = 0; k < NumInit; k++) begin
      cand = ptr_q + k;
      if (cand >= NumInit) begin
        cand = cand - NumInit;
      end
      if (!gnt_valid_o && req_i[cand]) begin
        gnt_valid_o = 1'b1;
        gnt_idx_o   = IdxWidth'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  // Winner gets lowest priority next time
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (gnt_valid_o) begin
      if (gnt_idx_o == IdxWidth'(NumInit - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= gnt_idx_o + 1'b1;
      end
    end
  end

endmodule

//--- local_interconnect.sv
// ----------------------------
// Local TCDM interconnect
// Word-interleaved decode, per-bank arbitration, read return
// ----------------------------

`timescale 1ns/100ps

module local_interconnect #(
  parameter int unsigned NumInit   = 5,
  parameter int unsigned NumBanks  = 8,
  parameter int unsigned BankDepth = 64
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Initiator side
  input  logic             [NumInit-1:0]              ini_valid_i,
  input  group_pkg::addr_t [NumInit-1:0]              ini_addr_i,
  input  logic             [NumInit-1:0]              ini_wen_i,
  input  group_pkg::data_t [NumInit-1:0]              ini_wdata_i,
  input  group_pkg::strb_t [NumInit-1:0]              ini_be_i,
  output logic             [NumInit-1:0]              ini_ready_o,
  output logic             [NumInit-1:0]              ini_resp_valid_o,
  output group_pkg::data_t [NumInit-1:0]              ini_rdata_o,
  // Bank side
  output logic             [NumBanks-1:0]             bank_req_o,
  output logic             [NumBanks-1:0]             bank_wen_o,
  output logic [NumBanks-1:0][$clog2(BankDepth)-1:0]  bank_row_o,
  output group_pkg::data_t [NumBanks-1:0]             bank_wdata_o,
  output group_pkg::strb_t [NumBanks-1:0]             bank_be_o,
  input  group_pkg::data_t [NumBanks-1:0]             bank_rdata_i
);

  localparam int unsigned BankSelWidth = $clog2(NumBanks);
  localparam int unsigned RowWidth     = $clog2(BankDepth);
  localparam int unsigned IdxWidth     = $clog2(NumInit);

  logic [NumInit-1:0][BankSelWidth-1:0] bank_sel;
  logic [NumInit-1:0][RowWidth-1:0]     row_sel;

  logic [NumBanks-1:0][NumInit-1:0]  bank_gnt;
  logic [NumInit-1:0][NumBanks-1:0]  ini_gnt;
  logic [NumBanks-1:0][IdxWidth-1:0] bank_idx;
  logic [NumBanks-1:0]               bank_gnt_valid;

  // Per-bank read tracking for the response cycle
  logic [NumBanks-1:0]               rd_q;
  logic [NumBanks-1:0][IdxWidth-1:0] idx_q;

  // ----------------------------
  // Address decode
  // ----------------------------

  for (genvar i = 0; i < NumInit; i++) begin : gen_decode
    assign bank_sel[i]    = ini_addr_i[i][BankSelWidth-1:0];
    assign row_sel[i]     = ini_addr_i[i][BankSelWidth +: RowWidth];
    assign ini_ready_o[i] = |ini_gnt[i];
  end

  // ----------------------------
  // Bank arbitration and request mux
  // ----------------------------

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    logic [NumInit-1:0] req;

    for (genvar i = 0; i < NumInit; i++) begin : gen_req
      assign req[i]        = ini_valid_i[i] && (bank_sel[i] == BankSelWidth'(b));
      assign ini_gnt[i][b] = bank_gnt[b][i];
    end

    bank_arbiter #(
      .NumInit(NumInit)
    ) i_bank_arbiter (
      .clk_i      (clk_i            ),
      .rst_n_i    (rst_n_i          ),
      .req_i      (req              ),
      .gnt_o      (bank_gnt[b]      ),
      .gnt_idx_o  (bank_idx[b]      ),
      .gnt_valid_o(bank_gnt_valid[b])
    );

    assign bank_req_o[b]   = bank_gnt_valid[b];
    assign bank_wen_o[b]   = ini_wen_i[bank_idx[b]];
    assign bank_row_o[b]   = row_sel[bank_idx[b]];
    assign bank_wdata_o[b] = ini_wdata_i[bank_idx[b]];
    assign bank_be_o[b]    = ini_be_i[bank_idx[b]];
  end

  // ----------------------------
  // Response return
  // ----------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_q <= '0;
    end else begin
      rd_q <= bank_gnt_valid & ~bank_wen_o;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (bank_gnt_valid[b]) begin
        idx_q[b] <= bank_idx[b];
      end
    end
  end

  // An initiator has at most one read in flight
  always_comb begin
    ini_resp_valid_o = '0;
    ini_rdata_o      = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (rd_q[b]) begin
        ini_resp_valid_o[idx_q[b]] = 1'b1;
        ini_rdata_o[idx_q[b]]      = bank_rdata_i[b];
      end
    end
  end

endmodule

//--- dma_fsm.sv
// ----------------------------
// DMA control FSM
// One read then one write per word
// ----------------------------

`timescale 1ns/100ps

module dma_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic desc_valid_i,
  input  logic len_zero_i,
  input  logic gnt_i,
  input  logic resp_valid_i,
  input  logic last_i,
  output logic desc_ready_o,
  output logic busy_o,
  output logic done_o,
  output logic rd_phase_o,
  output logic req_valid_o,
  output logic wen_o,
  output logic count_en_o
);

  localparam logic [2:0] StIdle  = 3'd0;
  localparam logic [2:0] StRead  = 3'd1;
  localparam logic [2:0] StWait  = 3'd2;
  localparam logic [2:0] StWrite = 3'd3;
  localparam logic [2:0] StDone  = 3'd4;

  logic [2:0] state_q;
  logic [2:0] state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (desc_valid_i) begin
          // Empty transfer skips all memory access
          state_d = len_zero_i ? StDone : StRead;
        end
      end
      StRead: begin
        if (gnt_i) begin
          state_d = StWait;
        end
      end
      StWait: begin
        if (resp_valid_i) begin
          state_d = StWrite;
        end
      end
      StWrite: begin
        if (gnt_i) begin
          state_d = last_i ? StDone : StRead;
        end
      end
      StDone: begin
        state_d = StIdle;
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign desc_ready_o = (state_q == StIdle);
  assign busy_o       = (state_q != StIdle);
  assign done_o       = (state_q == StDone);
  assign rd_phase_o   = (state_q == StRead);
  assign req_valid_o  = (state_q == StRead) || (state_q == StWrite);
  assign wen_o        = (state_q == StWrite);
  // Word is complete once its write is taken
  assign count_en_o   = (state_q == StWrite) && gnt_i;

endmodule

//--- dma_word_counter.sv
// ----------------------------
// DMA word index counter
// ----------------------------

`timescale 1ns/100ps

module dma_word_counter (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            clear_i,
  input  logic            count_en_i,
  input  group_pkg::len_t len_i,
  output group_pkg::len_t index_o,
  output logic            last_o
);

  // New descriptor restarts at word zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      index_o <= '0;
    end else if (clear_i) begin
      index_o <= '0;
    end else if (count_en_i) begin
      index_o <= index_o + 1'b1;
    end
  end

  assign last_o = (index_o == len_i - 1'b1);

endmodule

//--- dma_copy_path.sv
// ----------------------------
// DMA copy datapath
// Descriptor registers, address select, read buffer
// ----------------------------

`timescale 1ns/100ps

module dma_copy_path (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             load_i,
  input  group_pkg::addr_t src_i,
  input  group_pkg::addr_t dst_i,
  input  group_pkg::len_t  len_i,
  input  logic             rd_phase_i,
  input  group_pkg::len_t  index_i,
  input  logic             resp_valid_i,
  input  group_pkg::data_t rdata_i,
  output group_pkg::addr_t addr_o,
  output group_pkg::data_t wdata_o,
  output group_pkg::len_t  len_o,
  output logic             len_zero_o
);

  import group_pkg::*;

  addr_t src_q;
  addr_t dst_q;
  len_t  len_q;
  data_t buf_q;

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      len_q <= '0;
    end else if (load_i) begin
      len_q <= len_i;
    end
  end

  // Holds the word between its read and its write
  always_ff @(posedge clk_i) begin
    if (resp_valid_i) begin
      buf_q <= rdata_i;
    end
  end

  // Sum wraps at the address width
  assign addr_o = rd_phase_i ? addr_t'(src_q + index_i) : addr_t'(dst_q + index_i);

  assign wdata_o = buf_q;
  assign len_o   = len_q;

  // Sampled by the FSM in the accept cycle
  assign len_zero_o = (len_i == '0);

endmodule

//--- mem_group_top.sv
// ----------------------------
// Memory group top level
// Core ports and DMA engine sharing the TCDM banks
// ----------------------------

`timescale 1ns/100ps

module mem_group_top #(
  parameter int unsigned NumPorts  = 4,
  parameter int unsigned NumBanks  = 8,
  parameter int unsigned BankDepth = 64
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Core ports
  input  logic             [NumPorts-1:0]   req_valid_i,
  input  group_pkg::addr_t [NumPorts-1:0]   req_addr_i,
  input  logic             [NumPorts-1:0]   req_wen_i,
  input  group_pkg::data_t [NumPorts-1:0]   req_wdata_i,
  input  group_pkg::strb_t [NumPorts-1:0]   req_be_i,
  output logic             [NumPorts-1:0]   req_ready_o,
  output logic             [NumPorts-1:0]   resp_valid_o,
  output group_pkg::data_t [NumPorts-1:0]   resp_rdata_o,
  // DMA descriptor and status
  input  logic                              dma_valid_i,
  input  group_pkg::addr_t                  dma_src_i,
  input  group_pkg::addr_t                  dma_dst_i,
  input  group_pkg::len_t                   dma_len_i,
  output logic                              dma_ready_o,
  output logic                              dma_busy_o,
  output logic                              dma_done_o
);

  import group_pkg::*;

  localparam int unsigned NumInit  = NumPorts + 1;
  localparam int unsigned RowWidth = $clog2(BankDepth);

  // ----------------------------
  // Initiator and bank wires
  // ----------------------------

  logic  [NumInit-1:0] ini_ready;
  logic  [NumInit-1:0] ini_resp_valid;
  data_t [NumInit-1:0] ini_rdata;

  logic  [NumBanks-1:0]               bank_req;
  logic  [NumBanks-1:0]               bank_wen;
  logic  [NumBanks-1:0][RowWidth-1:0] bank_row;
  data_t [NumBanks-1:0]               bank_wdata;
  strb_t [NumBanks-1:0]               bank_be;
  data_t [NumBanks-1:0]               bank_rdata;

  // DMA initiator
  logic  dma_accept;
  logic  dma_req_valid;
  logic  dma_wen;
  addr_t dma_addr;
  data_t dma_wdata;
  strb_t dma_be;
  logic  dma_rd_phase;
  logic  dma_count_en;
  logic  dma_last;
  logic  dma_len_zero;
  len_t  dma_len;
  len_t  dma_index;

  assign dma_accept = dma_valid_i && dma_ready_o;
  assign dma_be     = '1;

  // DMA takes the highest initiator index
  assign req_ready_o  = ini_ready[NumPorts-1:0];
  assign resp_valid_o = ini_resp_valid[NumPorts-1:0];
  assign resp_rdata_o = ini_rdata[NumPorts-1:0];

  local_interconnect #(
    .NumInit  (NumInit  ),
    .NumBanks (NumBanks ),
    .BankDepth(BankDepth)
  ) i_local_interconnect (
    .clk_i           (clk_i                        ),
    .rst_n_i         (rst_n_i                      ),
    .ini_valid_i     ({dma_req_valid, req_valid_i} ),
    .ini_addr_i      ({dma_addr, req_addr_i}       ),
    .ini_wen_i       ({dma_wen, req_wen_i}         ),
    .ini_wdata_i     ({dma_wdata, req_wdata_i}     ),
    .ini_be_i        ({dma_be, req_be_i}           ),
    .ini_ready_o     (ini_ready                    ),
    .ini_resp_valid_o(ini_resp_valid               ),
    .ini_rdata_o     (ini_rdata                    ),
    .bank_req_o      (bank_req                     ),
    .bank_wen_o      (bank_wen                     ),
    .bank_row_o      (bank_row                     ),
    .bank_wdata_o    (bank_wdata                   ),
    .bank_be_o       (bank_be                      ),
    .bank_rdata_i    (bank_rdata                   )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    tcdm_bank #(
      .BankDepth(BankDepth)
    ) i_tcdm_bank (
      .clk_i  (clk_i        ),
      .req_i  (bank_req[b]  ),
      .wen_i  (bank_wen[b]  ),
      .row_i  (bank_row[b]  ),
      .wdata_i(bank_wdata[b]),
      .be_i   (bank_be[b]   ),
      .rdata_o(bank_rdata[b])
    );
  end

  // ----------------------------
  // DMA engine
  // ----------------------------

  dma_fsm i_dma_fsm (
    .clk_i       (clk_i                   ),
    .rst_n_i     (rst_n_i                 ),
    .desc_valid_i(dma_valid_i             ),
    .len_zero_i  (dma_len_zero            ),
    .gnt_i       (ini_ready[NumPorts]     ),
    .resp_valid_i(ini_resp_valid[NumPorts]),
    .last_i      (dma_last                ),
    .desc_ready_o(dma_ready_o             ),
    .busy_o      (dma_busy_o              ),
    .done_o      (dma_done_o              ),
    .rd_phase_o  (dma_rd_phase            ),
    .req_valid_o (dma_req_valid           ),
    .wen_o       (dma_wen                 ),
    .count_en_o  (dma_count_en            )
  );

  dma_word_counter i_dma_word_counter (
    .clk_i     (clk_i       ),
    .rst_n_i   (rst_n_i     ),
    .clear_i   (dma_accept  ),
    .count_en_i(dma_count_en),
    .len_i     (dma_len     ),
    .index_o   (dma_index   ),
    .last_o    (dma_last    )
  );

  dma_copy_path i_dma_copy_path (
    .clk_i       (clk_i                   ),
    .rst_n_i     (rst_n_i                 ),
    .load_i      (dma_accept              ),
    .src_i       (dma_src_i               ),
    .dst_i       (dma_dst_i               ),
    .len_i       (dma_len_i               ),
    .rd_phase_i  (dma_rd_phase            ),
    .index_i     (dma_index               ),
    .resp_valid_i(ini_resp_valid[NumPorts]),
    .rdata_i     (ini_rdata[NumPorts]     ),
    .addr_o      (dma_addr                ),
    .wdata_o     (dma_wdata               ),
    .len_o       (dma_len                 ),
    .len_zero_o  (dma_len_zero            )
  );

endmodule

//--- tb_mem_group.sv
// ----------------------------
// Self-checking testbench for the memory group
// Table of core, DMA and mixed accesses against a reference memory
// ----------------------------

`timescale 1ns/100ps

module tb_mem_group;

  import group_pkg::*;

  localparam int unsigned NumPorts   = 4;
  localparam int unsigned NumBanks   = 8;
  localparam int unsigned BankDepth  = 64;
  localparam int unsigned MemWords   = NumBanks * BankDepth;
  localparam int unsigned NumEntries = 12;
  localparam int unsigned MaxLen     = 16;
  localparam int unsigned CycleLimit = NumEntries * (NumPorts + 2) * MaxLen * 4 + 2500;

  localparam logic [2:0] OpWrite  = 3'd0;
  localparam logic [2:0] OpRead   = 3'd1;
  localparam logic [2:0] OpDma    = 3'd2;
  localparam logic [2:0] OpPar    = 3'd3;
  localparam logic [2:0] OpDmaPar = 3'd4;

  typedef struct packed {
    logic [2:0] op;
    logic [2:0] port;
    addr_t      addr;
    data_t      data;
    strb_t      be;
    addr_t      src;
    addr_t      dst;
    len_t       len;
  } entry_t;

  logic                         clk_i;
  logic                         rst_n_i;
  logic  [NumPorts-1:0]         req_valid_i;
  addr_t [NumPorts-1:0]         req_addr_i;
  logic  [NumPorts-1:0]         req_wen_i;
  data_t [NumPorts-1:0]         req_wdata_i;
  strb_t [NumPorts-1:0]         req_be_i;
  logic  [NumPorts-1:0]         req_ready_o;
  logic  [NumPorts-1:0]         resp_valid_o;
  data_t [NumPorts-1:0]         resp_rdata_o;
  logic                         dma_valid_i;
  addr_t                        dma_src_i;
  addr_t                        dma_dst_i;
  len_t                         dma_len_i;
  logic                         dma_ready_o;
  logic                         dma_busy_o;
  logic                         dma_done_o;

  data_t       ref_mem [MemWords];
  entry_t      table_q [NumEntries];
  int unsigned errors;
  int unsigned checks;
  int unsigned cycle_cnt;

  mem_group_top #(
    .NumPorts (NumPorts ),
    .NumBanks (NumBanks ),
    .BankDepth(BankDepth)
  ) uut (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_valid_i (req_valid_i ),
    .req_addr_i  (req_addr_i  ),
    .req_wen_i   (req_wen_i   ),
    .req_wdata_i (req_wdata_i ),
    .req_be_i    (req_be_i    ),
    .req_ready_o (req_ready_o ),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o),
    .dma_valid_i (dma_valid_i ),
    .dma_src_i   (dma_src_i   ),
    .dma_dst_i   (dma_dst_i   ),
    .dma_len_i   (dma_len_i   ),
    .dma_ready_o (dma_ready_o ),
    .dma_busy_o  (dma_busy_o  ),
    .dma_done_o  (dma_done_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------
  // Checking and reference model
  // ----------------------------

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("FAIL at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic int unsigned word_index(input addr_t a);
    return a % MemWords;
  endfunction

  // Pattern built from every address bit
  function automatic data_t fill_word(input int unsigned a);
    logic [8:0] w;
    w = a[8:0];
    return {w, 7'h35, ~w, 7'h4B};
  endfunction

  task automatic model_write(input addr_t a, input data_t d, input strb_t be);
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        ref_mem[word_index(a)][8*i +: 8] = d[8*i +: 8];
      end
    end
  endtask

  // Word by word, forward, like the engine
  task automatic model_copy(input addr_t src, input addr_t dst, input len_t len);
    for (int unsigned i = 0; i < len; i++) begin
      ref_mem[word_index(addr_t'(dst + i))] = ref_mem[word_index(addr_t'(src + i))];
    end
  endtask

  // ----------------------------
  // Core port access
  // ----------------------------

  task automatic set_port(input int p, input logic wen, input addr_t a, input data_t d,
                          input strb_t be);
    req_wen_i[p]   = wen;
    req_addr_i[p]  = a;
    req_wdata_i[p] = d;
    req_be_i[p]    = be;
  endtask

  // Starts and ends on a falling edge
  task automatic run_ports(input logic [NumPorts-1:0] mask);
    logic [NumPorts-1:0] pending;
    logic [NumPorts-1:0] accepted;
    logic [NumPorts-1:0] resp_expect;
    int unsigned         wait_cnt [NumPorts];
    data_t               exp_rdata [NumPorts];
    int unsigned         grants;
    pending     = mask;
    resp_expect = '0;
    for (int p = 0; p < NumPorts; p++) begin
      wait_cnt[p] = 0;
    end
    req_valid_i = mask;
    do begin
      #2;
      for (int p = 0; p < NumPorts; p++) begin
        check_value(resp_valid_o[p], resp_expect[p], "resp_valid timing");
        if (resp_expect[p]) begin
          check_value(resp_rdata_o[p], exp_rdata[p], "read data");
        end
      end
      accepted = req_ready_o & pending;
      grants   = 0;
      for (int p = 0; p < NumPorts; p++) begin
        grants = grants + req_ready_o[p];
      end
      check_value(grants <= 1, 1'b1, "more than one grant to a bank");
      resp_expect = '0;
      for (int p = 0; p < NumPorts; p++) begin
        if (accepted[p]) begin
          check_value(wait_cnt[p] <= NumPorts, 1'b1, "grant latency bound");
          if (req_wen_i[p]) begin
            model_write(req_addr_i[p], req_wdata_i[p], req_be_i[p]);
          end else begin
            exp_rdata[p]   = ref_mem[word_index(req_addr_i[p])];
            resp_expect[p] = 1'b1;
          end
        end else if (pending[p]) begin
          wait_cnt[p] = wait_cnt[p] + 1;
        end
      end
      pending = pending & ~accepted;
      @(negedge clk_i);
      req_valid_i = req_valid_i & ~accepted;
    end while (pending != '0 || resp_expect != '0);
  endtask

  // All ports target one bank; odd ports write when be is nonzero
  task automatic setup_group(input entry_t e);
    for (int p = 0; p < NumPorts; p++) begin
      set_port(p, (e.be != '0) && (p % 2 == 1), addr_t'(e.addr + p * NumBanks),
               e.data ^ p, (e.be != '0) ? e.be : 4'hF);
    end
  endtask

  // ----------------------------
  // DMA access
  // ----------------------------

  task automatic fill_source(input entry_t e);
    for (int unsigned i = 0; i < e.len; i++) begin
      set_port(0, 1'b1, addr_t'(e.src + i), $urandom, 4'hF);
      run_ports(4'b0001);
    end
  endtask

  task automatic start_dma(input entry_t e);
    dma_valid_i = 1'b1;
    dma_src_i   = e.src;
    dma_dst_i   = e.dst;
    dma_len_i   = e.len;
    #2;
    while (!dma_ready_o) begin
      @(negedge clk_i);
      #2;
    end
    @(negedge clk_i);
    dma_valid_i = 1'b0;
  endtask

  task automatic finish_dma(input entry_t e);
    int unsigned num_read;
    // An empty copy still reads its first destination word
    num_read = (e.len == '0) ? 1 : e.len;
    #2;
    while (!dma_done_o) begin
      check_value(dma_busy_o, 1'b1, "busy while copying");
      @(negedge clk_i);
      #2;
    end
    check_value(dma_busy_o, 1'b1, "busy during done pulse");
    @(negedge clk_i);
    #2;
    check_value(dma_done_o, 1'b0, "done lasts one cycle");
    check_value(dma_ready_o, 1'b1, "ready after copy");
    @(negedge clk_i);
    model_copy(e.src, e.dst, e.len);
    for (int unsigned i = 0; i < num_read; i++) begin
      set_port(e.port, 1'b0, addr_t'(e.dst + i), '0, '0);
      run_ports(1 << e.port);
    end
  endtask

  function automatic entry_t make_entry(input logic [2:0] op, input int port, input addr_t a,
                                        input data_t d, input strb_t be, input addr_t src,
                                        input addr_t dst, input len_t len);
    entry_t e;
    e.op   = op;
    e.port = port;
    e.addr = a;
    e.data = d;
    e.be   = be;
    e.src  = src;
    e.dst  = dst;
    e.len  = len;
    return e;
  endfunction

  // ----------------------------
  // Main sequence
  // ----------------------------

  initial begin
    errors      = 0;
    checks      = 0;
    cycle_cnt   = 0;
    void'($urandom(32'h7879_ccd5));
    rst_n_i     = 1'b0;
    req_valid_i = '0;
    req_addr_i  = '0;
    req_wen_i   = '0;
    req_wdata_i = '0;
    req_be_i    = '0;
    dma_valid_i = 1'b0;
    dma_src_i   = '0;
    dma_dst_i   = '0;
    dma_len_i   = '0;

    table_q[0]  = make_entry(OpWrite, 0, 16'h0013, 32'hDEAD_BEEF, 4'b0101, 0, 0, 0);
    table_q[1]  = make_entry(OpRead, 2, 16'h0013, 0, 0, 0, 0, 0);
    // Upper address bits wrap onto the same word
    table_q[2]  = make_entry(OpWrite, 3, 16'h1213, 32'h1234_5678, 4'b1000, 0, 0, 0);
    table_q[3]  = make_entry(OpRead, 1, 16'h0013, 0, 0, 0, 0, 0);
    table_q[4]  = make_entry(OpPar, 0, 16'h0045, 0, 4'b0000, 0, 0, 0);
    table_q[5]  = make_entry(OpPar, 0, 16'h0102, 32'hCAFE_F00D, 4'b0011, 0, 0, 0);
    table_q[6]  = make_entry(OpDma, 0, 0, 0, 0, 16'h0020, 16'h0080, 16'(1 + $urandom % MaxLen));
    table_q[7]  = make_entry(OpDma, 1, 0, 0, 0, 16'h0100, 16'h0103, 16'd10);
    table_q[8]  = make_entry(OpDma, 2, 0, 0, 0, 16'h0040, 16'h0050, 16'd0);
    table_q[9]  = make_entry(OpDmaPar, 3, 16'h0006, 32'h0BAD_CAFE, 4'b1111, 16'h0140, 16'h0180,
                             16'd16);
    table_q[10] = make_entry(OpDmaPar, 0, 16'h0011, 0, 4'b0000, 16'h01C0, 16'h01F8, 16'd14);
    table_q[11] = make_entry(OpRead, 1, 16'h0102, 0, 0, 0, 0, 0);

    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    #2;
    check_value(resp_valid_o, '0, "resp_valid after reset");
    check_value(req_ready_o, '0, "req_ready after reset");
    check_value(dma_busy_o, 1'b0, "dma_busy after reset");
    check_value(dma_done_o, 1'b0, "dma_done after reset");
    check_value(dma_ready_o, 1'b1, "dma_ready after reset");
    @(negedge clk_i);

    // Known contents everywhere before the table runs
    for (int unsigned a = 0; a < MemWords; a++) begin
      set_port(0, 1'b1, addr_t'(a), fill_word(a), 4'hF);
      run_ports(4'b0001);
    end

    for (int n = 0; n < NumEntries; n++) begin
      case (table_q[n].op)
        OpWrite: begin
          set_port(table_q[n].port, 1'b1, table_q[n].addr, table_q[n].data, table_q[n].be);
          run_ports(1 << table_q[n].port);
        end
        OpRead: begin
          set_port(table_q[n].port, 1'b0, table_q[n].addr, '0, '0);
          run_ports(1 << table_q[n].port);
        end
        OpPar: begin
          setup_group(table_q[n]);
          run_ports('1);
        end
        OpDma: begin
          fill_source(table_q[n]);
          start_dma(table_q[n]);
          finish_dma(table_q[n]);
        end
        default: begin
          fill_source(table_q[n]);
          start_dma(table_q[n]);
          setup_group(table_q[n]);
          run_ports('1);
          finish_dma(table_q[n]);
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
group_pkg.sv
tcdm_bank.sv
bank_arbiter.sv
local_interconnect.sv
dma_fsm.sv
dma_word_counter.sv
dma_copy_path.sv
mem_group_top.sv
tb_mem_group.sv
